//--- files.f
source/lspPkg.sv
source/memBus.sv
source/scratchMemory.sv
source/scratchArbiter.sv
source/distanceFetch.sv
source/modeDecide.sv
source/lspLastSelectTop.sv
tests/lspLastSelectTb.sv

//--- source/distanceFetch.sv
`timescale 1ns/100ps

module distanceFetch
	import lspPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic start,
	input addrT lTdist,
	input addrT modeAddr,
	output logic stageBusy,
	input logic otherBusy,
	memBus.requester mem,
	distPair.source pair
);

	fetchStateT state;
	addrT baseAddr;
	addrT modeAddrReg;
	wordT dist0Reg;
	logic accept;

	// Start is dropped unless both stages are free
	assign accept = start && !otherBusy && (state == fetchIdle);
	assign stageBusy = (state != fetchIdle);

	//////////////////////////////////////////////////////////////////////
	// Read sequence
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			state <= fetchIdle;
		else
		begin
			case (state)
				fetchIdle:
					if (accept)
						state <= fetchReadFirst;
				fetchReadFirst:
					state <= fetchReadSecond;
				fetchReadSecond:
					state <= fetchHandOver;
				default:
					state <= fetchIdle;
			endcase
		end
	end

	// Job addresses latched at start, dist0 off the RAM output
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			baseAddr <= lTdist;
			modeAddrReg <= modeAddr;
		end
		if (state == fetchReadSecond)
			dist0Reg <= mem.readData;
	end

	// Read only, base then base+1
	assign mem.req = (state == fetchReadFirst) || (state == fetchReadSecond);
	assign mem.addr = (state == fetchReadSecond) ? baseAddr + addrT'(1) : baseAddr;
	assign mem.writeEn = 1'b0;
	assign mem.writeData = '0;

	// dist1 sits on the RAM output during hand-over
	assign pair.valid = (state == fetchHandOver);
	assign pair.dist0 = dist0Reg;
	assign pair.dist1 = mem.readData;
	assign pair.modeAddr = modeAddrReg;

endmodule

//--- source/lspLastSelectTop.sv
`timescale 1ns/100ps

module lspLastSelectTop
	import lspPkg::*;
#(
	parameter int memDepth = 4096
)
(
	input logic clk,
	input logic rstN,
	// Engine control
	input logic start,
	input addrT lTdist,
	input addrT modeAddr,
	output logic done,
	output logic busy,
	output modeT modeIndex,
	// Wishbone classic, host access to scratch
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input addrT wbAdr,
	input wordT wbDatW,
	output wordT wbDatR,
	output logic wbAck
);

	memBus fetchBus();
	memBus decideBus();
	distPair pair();

	logic fetchBusy;
	logic decideBusy;
	logic ramWriteEn;
	addrT ramAddr;
	wordT ramWriteData;
	wordT ramReadData;

	// Busy over both stages
	assign busy = fetchBusy | decideBusy;

	distanceFetch fetchStage (.clk(clk), .rstN(rstN), .start(start), .lTdist(lTdist),
		.modeAddr(modeAddr), .stageBusy(fetchBusy), .otherBusy(decideBusy),
		.mem(fetchBus.requester), .pair(pair.source));

	modeDecide decideStage (.clk(clk), .rstN(rstN), .pair(pair.sink), .mem(decideBus.requester),
		.stageBusy(decideBusy), .done(done), .modeIndex(modeIndex));

	scratchArbiter #(.memDepth(memDepth)) arbiter (.clk(clk), .rstN(rstN), .wbCyc(wbCyc),
		.wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR),
		.wbAck(wbAck), .fetchBus(fetchBus.arbiter), .decideBus(decideBus.arbiter),
		.ramWriteEn(ramWriteEn), .ramAddr(ramAddr), .ramWriteData(ramWriteData),
		.ramReadData(ramReadData));

	// Single address drives both RAM ports
	scratchMemory #(.memDepth(memDepth)) scratch (.clk(clk), .writeEn(ramWriteEn),
		.writeAddr(ramAddr), .writeData(ramWriteData), .readAddr(ramAddr),
		.readData(ramReadData));

endmodule

//--- source/lspPkg.sv
package lspPkg;

	//////////////////////////////////////////////////////////////////////
	// Codec word and address types
	//////////////////////////////////////////////////////////////////////

	// Signed distortion or data word
	typedef logic signed [31:0] wordT;

	// Scratch memory address
	typedef logic [11:0] addrT;

	// Selected codebook index
	typedef logic [0:0] modeT;

	// Saturation limits of a word
	localparam wordT wordMax = 32'sh7FFF_FFFF;
	localparam wordT wordMin = 32'sh8000_0000;

	//////////////////////////////////////////////////////////////////////
	// Stage FSM encodings
	//////////////////////////////////////////////////////////////////////

	// Fetch stage, two reads then one hand-over cycle
	typedef enum logic [1:0] {
		fetchIdle,
		fetchReadFirst,
		fetchReadSecond,
		fetchHandOver
	} fetchStateT;

	// Decide stage
	typedef enum logic [1:0] {decideIdle, decideCompute, decideWrite} decideStateT;

endpackage

//--- source/memBus.sv
`timescale 1ns/100ps

// One access path into the scratch arbiter
interface memBus
	import lspPkg::*;
();
	addrT addr;
	wordT writeData;
	logic writeEn;
	logic req;
	// Registered RAM output, one cycle behind addr
	wordT readData;

	modport requester (output addr, writeData, writeEn, req, input readData);
	modport arbiter (input addr, writeData, writeEn, req, output readData);
endinterface

// Distortion pair from fetch to decide
interface distPair
	import lspPkg::*;
();
	wordT dist0;
	wordT dist1;
	addrT modeAddr;
	// Single-cycle offer, decide is always ready when idle
	logic valid;

	modport source (output dist0, dist1, modeAddr, valid);
	modport sink (input dist0, dist1, modeAddr, valid);
endinterface

//--- source/modeDecide.sv
`timescale 1ns/100ps

module modeDecide
	import lspPkg::*;
(
	input logic clk,
	input logic rstN,
	distPair.sink pair,
	memBus.requester mem,
	output logic stageBusy,
	output logic done,
	output modeT modeIndex
);

	decideStateT state;
	wordT dist0Reg;
	wordT dist1Reg;
	addrT modeAddrReg;
	logic [32:0] wideDiff;
	wordT satDiff;

	//////////////////////////////////////////////////////////////////////
	// Saturating dist1 - dist0
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// One guard bit catches overflow
		wideDiff = {dist1Reg[31], dist1Reg} - {dist0Reg[31], dist0Reg};
		if (wideDiff[32] != wideDiff[31])
			satDiff = wideDiff[32] ? wordMin : wordMax;
		else
			satDiff = wideDiff[31:0];
	end

	//////////////////////////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= decideIdle;
			done <= 1'b0;
			modeIndex <= '0;
		end
		else
		begin
			// Pulse once the mode word is in the RAM
			done <= (state == decideWrite);
			case (state)
				decideIdle:
					if (pair.valid)
						state <= decideCompute;
				decideCompute:
				begin
					// Negative difference picks codebook 1
					modeIndex <= satDiff[31];
					state <= decideWrite;
				end
				default:
					state <= decideIdle;
			endcase
		end
	end

	// Pair taken in idle only
	always_ff @(posedge clk)
	begin
		if (state == decideIdle && pair.valid)
		begin
			dist0Reg <= pair.dist0;
			dist1Reg <= pair.dist1;
			modeAddrReg <= pair.modeAddr;
		end
	end

	assign stageBusy = (state != decideIdle);

	// Writeback, mode zero-extended to a word
	assign mem.req = (state == decideWrite);
	assign mem.writeEn = (state == decideWrite);
	assign mem.addr = modeAddrReg;
	assign mem.writeData = {31'b0, modeIndex};

endmodule

//--- source/scratchArbiter.sv
`timescale 1ns/100ps

module scratchArbiter
	import lspPkg::*;
#(
	parameter int memDepth = 4096
)
(
	input logic clk,
	input logic rstN,
	// Wishbone classic slave
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input addrT wbAdr,
	input wordT wbDatW,
	output wordT wbDatR,
	output logic wbAck,
	// Engine stages
	memBus.arbiter fetchBus,
	memBus.arbiter decideBus,
	// RAM side
	output logic ramWriteEn,
	output addrT ramAddr,
	output wordT ramWriteData,
	input wordT ramReadData
);

	typedef enum logic [1:0] {wbIdle, wbWaitData, wbAcknowledge} wbStateT;

	wbStateT wbState;
	addrT hostAddr;
	wordT hostData;
	logic hostWe;
	logic engineReq;
	logic hostGrant;
	logic hostInRange;

	//////////////////////////////////////////////////////////////////////
	// Wishbone sequence
	//////////////////////////////////////////////////////////////////////

	assign engineReq = fetchBus.req | decideBus.req;
	// Host only gets the RAM when no stage asks for it
	assign hostGrant = (wbState == wbWaitData) && !engineReq;
	assign hostInRange = int'(hostAddr) < memDepth;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			wbState <= wbIdle;
		else
		begin
			case (wbState)
				wbIdle:
					if (wbCyc && wbStb)
						wbState <= wbWaitData;
				// Stall here while the engine holds the RAM
				wbWaitData:
					if (!engineReq)
						wbState <= wbAcknowledge;
				default:
					wbState <= wbIdle;
			endcase
		end
	end

	// Host request held from the first strobe cycle
	always_ff @(posedge clk)
	begin
		if (wbState == wbIdle && wbCyc && wbStb)
		begin
			hostAddr <= wbAdr;
			hostData <= wbDatW;
			hostWe <= wbWe;
		end
	end

	assign wbAck = (wbState == wbAcknowledge);
	// Reads beyond the array give zero
	assign wbDatR = hostInRange ? ramReadData : '0;

	//////////////////////////////////////////////////////////////////////
	// RAM mux, fetch before decide before host
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (fetchBus.req)
		begin
			ramAddr = fetchBus.addr;
			ramWriteData = fetchBus.writeData;
			ramWriteEn = fetchBus.writeEn;
		end
		else if (decideBus.req)
		begin
			ramAddr = decideBus.addr;
			ramWriteData = decideBus.writeData;
			ramWriteEn = decideBus.writeEn;
		end
		else
		begin
			ramAddr = hostAddr;
			ramWriteData = hostData;
			ramWriteEn = hostGrant && hostWe && hostInRange;
		end
	end

	// Both stages see the shared read port
	assign fetchBus.readData = ramReadData;
	assign decideBus.readData = ramReadData;

endmodule

//--- source/scratchMemory.sv
`timescale 1ns/100ps

module scratchMemory
	import lspPkg::*;
#(
	parameter int memDepth = 4096
)
(
	input logic clk,
	// Write port
	input logic writeEn,
	input addrT writeAddr,
	input wordT writeData,
	// Read port
	input addrT readAddr,
	output wordT readData
);

	// Storage array, contents undefined after power-up
	wordT ram [memDepth];

	// Write side
	always_ff @(posedge clk)
	begin
		if (writeEn)
			ram[writeAddr] <= writeData;
	end

	// Registered read
	// Same-cycle write to the same address returns the old word
	always_ff @(posedge clk)
	begin
		readData <= ram[readAddr];
	end

endmodule

//--- tests/lspLastSelectTb.sv
`timescale 1ns/100ps

module lspLastSelectTb
	import lspPkg::*;
();

	localparam int clkPeriod = 10;
	// 56 engine jobs plus the Wishbone test
	localparam int jobCount = 57;

	logic clk;
	logic rstN;
	logic start;
	addrT lTdist;
	addrT modeAddr;
	logic done;
	logic busy;
	modeT modeIndex;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	addrT wbAdr;
	wordT wbDatW;
	wordT wbDatR;
	logic wbAck;
	int errorCount;
	int checkCount;

	lspLastSelectTop DUT (.clk(clk), .rstN(rstN), .start(start), .lTdist(lTdist),
		.modeAddr(modeAddr), .done(done), .busy(busy), .modeIndex(modeIndex), .wbCyc(wbCyc),
		.wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR),
		.wbAck(wbAck));

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Hard stop for a hung handshake
	initial
	begin
		repeat (200 * jobCount + 100) @(posedge clk);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and checks
	//////////////////////////////////////////////////////////////////////

	// Sign of the saturated dist1 - dist0 gives the codebook
	function automatic modeT expectMode(wordT d0, wordT d1);
		longint diff;
		wordT sat;
		diff = longint'(d1) - longint'(d0);
		if (diff > longint'(wordMax))
			sat = wordMax;
		else if (diff < longint'(wordMin))
			sat = wordMin;
		else
			sat = wordT'(diff);
		return modeT'(sat < 0);
	endfunction

	// Fill word built from every address bit
	function automatic wordT patternFor(addrT a);
		return {a, 8'h5A, a};
	endfunction

	task automatic compareWord(input wordT actual, input wordT expected, input string what);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAIL %0t: %s got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic compareMode(input modeT actual, input modeT expected, input string what);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAIL %0t: %s got %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic compareFlag(input logic actual, input logic expected, input string what);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAIL %0t: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Wishbone host and engine drivers
	//////////////////////////////////////////////////////////////////////

	// One classic cycle held until ack
	task automatic wbAccess(input logic we, input addrT a, input wordT wdata, output wordT rdata);
		int waitCycles;
		waitCycles = 0;
		rdata = '0;
		@(negedge clk);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = a;
		wbDatW = wdata;
		while (!wbAck && waitCycles < 50)
		begin
			@(posedge clk);
			waitCycles++;
			@(negedge clk);
		end
		if (!wbAck)
		begin
			errorCount++;
			$display("Wishbone access to address %h never got an acknowledge", a);
		end
		else
		begin
			rdata = wbDatR;
			// Address register plus RAM read
			if (waitCycles < 2)
			begin
				errorCount++;
				$display("FAIL %0t: wbAck after %0d cycles, minimum is 2", $time, waitCycles);
			end
		end
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic wbWrite(input addrT a, input wordT data);
		wordT unused;
		wbAccess(1'b1, a, data, unused);
	endtask

	task automatic wbRead(input addrT a, output wordT data);
		wbAccess(1'b0, a, '0, data);
	endtask

	// Pulse start and count cycles to done
	// Retrigger keeps start high with a decoy mode address while busy
	task automatic startJob(input addrT base, input addrT modeA, input logic retrigger,
		output int cycles);
		@(negedge clk);
		start = 1'b1;
		lTdist = base;
		modeAddr = modeA;
		@(posedge clk);
		@(negedge clk);
		start = retrigger;
		modeAddr = modeA ^ addrT'(12'h400);
		cycles = 0;
		while (!done && cycles < 50)
		begin
			// Engine holds busy until done
			compareFlag(busy, 1'b1, "busy during job");
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end
		start = 1'b0;
		if (!done)
		begin
			errorCount++;
			$display("Job at base %h never raised done", base);
		end
	endtask

	// Full job with preload, latency, mode and memory checks
	task automatic runJob(input wordT d0, input wordT d1, input addrT base, input addrT modeA,
		input logic retrigger);
		wordT rd;
		int cycles;
		modeT expMode;
		addrT decoy;
		expMode = expectMode(d0, d1);
		decoy = modeA ^ addrT'(12'h400);
		wbWrite(base, d0);
		wbWrite(base + addrT'(1), d1);
		wbWrite(modeA - addrT'(1), patternFor(modeA - addrT'(1)));
		wbWrite(modeA, patternFor(modeA));
		wbWrite(modeA + addrT'(1), patternFor(modeA + addrT'(1)));
		wbWrite(decoy, patternFor(decoy));
		startJob(base, modeA, retrigger, cycles);
		if (cycles != 5)
		begin
			errorCount++;
			$display("FAIL %0t: done came %0d cycles after start, expected 5", $time, cycles);
		end
		compareMode(modeIndex, expMode, "modeIndex");
		// Ignored start leaves the engine quiet
		repeat (8)
		begin
			@(negedge clk);
			compareFlag(done, 1'b0, "done after job");
			compareFlag(busy, 1'b0, "busy after job");
		end
		wbRead(modeA, rd);
		compareWord(rd, {31'b0, expMode}, "stored mode word");
		wbRead(modeA - addrT'(1), rd);
		compareWord(rd, patternFor(modeA - addrT'(1)), "word below modeAddr");
		wbRead(modeA + addrT'(1), rd);
		compareWord(rd, patternFor(modeA + addrT'(1)), "word above modeAddr");
		wbRead(decoy, rd);
		compareWord(rd, patternFor(decoy), "decoy mode word");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic testWishbone();
		addrT addrs [16];
		wordT words [16];
		wordT rd;
		// One address per 256-word block, so no two collide
		for (int i = 0; i < 16; i++)
		begin
			addrs[i] = addrT'(i * 256 + ($urandom % 256));
			words[i] = wordT'($urandom);
			wbWrite(addrs[i], words[i]);
		end
		for (int i = 0; i < 16; i++)
		begin
			wbRead(addrs[i], rd);
			compareWord(rd, words[i], "Wishbone read back");
		end
	endtask

	task automatic testDirected();
		runJob(32'sd1000, 32'sd200, 12'h010, 12'h800, 1'b0);
		runJob(32'sd777, 32'sd777, 12'h020, 12'h810, 1'b0);
		runJob(32'sd5, 32'sd90000, 12'h030, 12'h820, 1'b0);
		// Wrapping subtraction would flip both of these
		runJob(32'sh0000_0001, 32'sh8000_0000, 12'h040, 12'h830, 1'b0);
		runJob(32'shFFFF_FFFF, 32'sh7FFF_FFFF, 12'h050, 12'h840, 1'b0);
	endtask

	task automatic testRandom();
		addrT base;
		addrT modeA;
		for (int i = 0; i < 50; i++)
		begin
			// Pair in the low half and mode word in the high half
			base = addrT'($urandom % 2047);
			modeA = addrT'(2049 + ($urandom % 2046));
			runJob(wordT'($urandom), wordT'($urandom), base, modeA, 1'b0);
		end
	endtask

	task automatic testRetrigger();
		runJob(32'sd400, 32'sd300, 12'h100, 12'h900, 1'b1);
	endtask

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		rstN = 1'b0;
		start = 1'b0;
		lTdist = '0;
		modeAddr = '0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		void'($urandom(40915));
		repeat (8) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		compareFlag(done, 1'b0, "done after reset");
		compareFlag(busy, 1'b0, "busy after reset");
		compareFlag(wbAck, 1'b0, "wbAck after reset");
		testWishbone();
		testDirected();
		testRandom();
		testRetrigger();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
